// ==== Makefile ====
SHELL     := /bin/bash

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= eth_ingress_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	set -o pipefail; ./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	! grep -q "STATUS: FAIL" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/cdc_len_fifo.sv ====
`timescale 1ns/1ps
`include "eth_ingress_config.svh"

module cdc_len_fifo
	import eth_ingress_pkg::*;
(
	input  logic       wr_clk,
	input  logic       wr_reset,
	input  logic       wr_en,
	input  frame_len_u wr_data,
	input  logic       rd_clk,
	input  logic       rd_reset,
	input  logic       rd_en,
	output logic       wr_full,
	output frame_len_u rd_data,
	output logic       rd_empty
);

	localparam int AW = `LEN_PTR_BITS;
	localparam int PW = `LEN_PTR_BITS + 1;

	frame_len_u    ram [`LEN_FIFO_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] wr_next;
	logic [PW-1:0] wr_gray;
	logic [PW-1:0] rd_ptr;
	logic [PW-1:0] rd_next;
	logic [PW-1:0] rd_gray;
	logic [PW-1:0] rd_gray_meta;
	logic [PW-1:0] rd_gray_sync;
	logic [PW-1:0] wr_gray_meta;
	logic [PW-1:0] wr_gray_sync;

	assign wr_next = wr_ptr + 1'b1;
	assign rd_next = rd_ptr + 1'b1;

	// Full when the pointers differ only in the top two Gray bits
	assign wr_full  = wr_gray == {~rd_gray_sync[PW-1:PW-2], rd_gray_sync[PW-3:0]};
	assign rd_empty = rd_gray == wr_gray_sync;

	always_ff @(posedge wr_clk) begin
		if (wr_reset) begin
			wr_ptr       <= '0;
			wr_gray      <= '0;
			rd_gray_meta <= '0;
			rd_gray_sync <= '0;
		end else begin
			rd_gray_meta <= rd_gray;
			rd_gray_sync <= rd_gray_meta;
			if (wr_en && !wr_full) begin
				wr_ptr  <= wr_next;
				wr_gray <= wr_next ^ (wr_next >> 1);
			end
		end
	end

	always_ff @(posedge wr_clk) begin
		if (wr_en && !wr_full)
			ram[wr_ptr[AW-1:0]] <= wr_data;
	end

	always_ff @(posedge rd_clk) begin
		if (rd_reset) begin
			rd_ptr       <= '0;
			rd_gray      <= '0;
			wr_gray_meta <= '0;
			wr_gray_sync <= '0;
		end else begin
			wr_gray_meta <= wr_gray;
			wr_gray_sync <= wr_gray_meta;
			if (rd_en && !rd_empty) begin
				rd_ptr  <= rd_next;
				rd_gray <= rd_next ^ (rd_next >> 1);
			end
		end
	end

	// Output register, valid the cycle after rd_en
	always_ff @(posedge rd_clk) begin
		if (rd_en && !rd_empty)
			rd_data <= ram[rd_ptr[AW-1:0]];
	end

endmodule

// ==== design/cdc_packet_fifo.sv ====
`timescale 1ns/1ps
`include "eth_ingress_config.svh"

module cdc_packet_fifo
	import eth_ingress_pkg::*;
(
	input  logic                       wr_clk,
	input  logic                       wr_reset,
	input  logic                       wr_en,
	input  mem_word_u                  wr_data,
	input  logic                       wr_commit,
	input  logic                       wr_rollback,
	output logic [`DATA_PTR_BITS:0]    wr_free,
	input  logic                       rd_clk,
	input  logic                       rd_reset,
	input  logic                       rd_en,
	input  logic [`DATA_PTR_BITS-1:0]  rd_offset,
	input  logic                       pop_packet,
	input  logic [`DATA_PTR_BITS:0]    pop_words,
	output mem_word_u                  rd_data
);

	localparam int AW = `DATA_PTR_BITS;
	localparam int PW = `DATA_PTR_BITS + 1;

	function automatic logic [PW-1:0] bin2gray(input logic [PW-1:0] b);
		return b ^ (b >> 1);
	endfunction

	function automatic logic [PW-1:0] gray2bin(input logic [PW-1:0] g);
		logic [PW-1:0] b;
		b[PW-1] = g[PW-1];
		for (int i = PW - 2; i >= 0; i--)
			b[i] = b[i+1] ^ g[i];
		return b;
	endfunction

	mem_word_u     ram [`DATA_FIFO_DEPTH];

	// Write side state
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] cmt_ptr;
	logic [PW-1:0] cmt_gray;
	logic [PW-1:0] rd_meta_w;
	logic [PW-1:0] rd_sync_w;
	logic [PW-1:0] used;

	// Read side state
	logic [PW-1:0] rd_ptr;
	logic [PW-1:0] rd_gray;
	logic [PW-1:0] cmt_meta;
	logic [PW-1:0] cmt_sync;
	logic [PW-1:0] cmt_bin_r;
	logic [PW-1:0] rd_avail;
	logic [AW-1:0] rd_addr;

	////////////////////////////////////////////////////////////
	// Write side

	// Space counts against the tentative pointer
	assign used    = wr_ptr - gray2bin(rd_sync_w);
	assign wr_free = PW'(`DATA_FIFO_DEPTH) - used;

	always_ff @(posedge wr_clk) begin
		if (wr_reset) begin
			wr_ptr    <= '0;
			cmt_ptr   <= '0;
			cmt_gray  <= '0;
			rd_meta_w <= '0;
			rd_sync_w <= '0;
		end else begin
			// Rollback wins over a push in the same cycle
			if (wr_rollback)
				wr_ptr <= cmt_ptr;
			else if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (wr_commit)
				cmt_ptr <= wr_en ? wr_ptr + 1'b1 : wr_ptr;
			// Only whole frames are published
			cmt_gray  <= bin2gray(cmt_ptr);
			rd_meta_w <= rd_gray;
			rd_sync_w <= rd_meta_w;
		end
	end

	always_ff @(posedge wr_clk) begin
		if (wr_en)
			ram[wr_ptr[AW-1:0]] <= wr_data;
	end

	////////////////////////////////////////////////////////////
	// Read side

	assign cmt_bin_r = gray2bin(cmt_sync);
	assign rd_avail  = cmt_bin_r - rd_ptr;
	assign rd_addr   = rd_ptr[AW-1:0] + rd_offset;

	always_ff @(posedge rd_clk) begin
		if (rd_reset) begin
			rd_ptr   <= '0;
			rd_gray  <= '0;
			cmt_meta <= '0;
			cmt_sync <= '0;
		end else begin
			cmt_meta <= cmt_gray;
			cmt_sync <= cmt_meta;
			// Never pop past committed data
			if (pop_packet) begin
				if (pop_words > rd_avail)
					rd_ptr <= cmt_bin_r;
				else
					rd_ptr <= rd_ptr + pop_words;
			end
			rd_gray <= bin2gray(rd_ptr);
		end
	end

	// Registered read, one cycle after rd_en
	always_ff @(posedge rd_clk) begin
		if (rd_en)
			rd_data <= ram[rd_addr];
	end

endmodule

// ==== design/eth_ingress_cdc.sv ====
`timescale 1ns/1ps
`include "eth_ingress_config.svh"

module eth_ingress_cdc
	import eth_ingress_pkg::*;
(
	// MAC side
	input  logic                       rx_clk,
	input  logic                       link_up,
	input  logic                       rx_start,
	input  logic                       rx_data_valid,
	input  logic [`LANE_BITS-1:0]      rx_data,
	input  logic [2:0]                 rx_bytes_valid,
	input  logic                       rx_commit,
	input  logic                       rx_drop,
	// Memory arbiter side
	input  logic                       clk_mem,
	input  logic                       rst,
	input  logic                       mem_frame_start,
	output logic                       mem_frame_ready,
	output logic [`LEN_BITS-1:0]       mem_frame_bytelen,
	output logic                       mem_valid,
	output logic [`MEM_WORD_BITS-1:0]  mem_data,
	output logic                       mem_frame_done
);

	// rx_clk domain
	logic                       wr_reset;
	logic                       wr_en;
	mem_word_u                  wr_data;
	logic                       wr_commit;
	logic                       wr_rollback;
	logic [`DATA_PTR_BITS:0]    wr_free;
	logic                       len_wr_en;
	frame_len_u                 len_wr_data;
	logic                       len_full;

	// clk_mem domain
	logic                       rd_reset;
	logic                       rd_en;
	logic [`DATA_PTR_BITS-1:0]  rd_offset;
	logic                       pop_packet;
	logic [`DATA_PTR_BITS:0]    pop_words;
	mem_word_u                  rd_data;
	logic                       len_rd_en;
	frame_len_u                 len_rd_data;
	logic                       len_empty;

	rx_width_expander u_expander (
		.rx_clk         (rx_clk),
		.wr_reset       (wr_reset),
		.rx_start       (rx_start),
		.rx_data_valid  (rx_data_valid),
		.rx_data        (rx_data),
		.rx_bytes_valid (rx_bytes_valid),
		.rx_commit      (rx_commit),
		.rx_drop        (rx_drop),
		.wr_free        (wr_free),
		.len_full       (len_full),
		.wr_en          (wr_en),
		.wr_data        (wr_data),
		.wr_commit      (wr_commit),
		.wr_rollback    (wr_rollback),
		.len_wr_en      (len_wr_en),
		.len_wr_data    (len_wr_data)
	);

	ingress_link_reset u_link_reset (
		.rx_clk   (rx_clk),
		.clk_mem  (clk_mem),
		.rst      (rst),
		.link_up  (link_up),
		.wr_reset (wr_reset),
		.rd_reset (rd_reset)
	);

	// Frame payload
	cdc_packet_fifo u_data_fifo (
		.wr_clk      (rx_clk),
		.wr_reset    (wr_reset),
		.wr_en       (wr_en),
		.wr_data     (wr_data),
		.wr_commit   (wr_commit),
		.wr_rollback (wr_rollback),
		.wr_free     (wr_free),
		.rd_clk      (clk_mem),
		.rd_reset    (rd_reset),
		.rd_en       (rd_en),
		.rd_offset   (rd_offset),
		.pop_packet  (pop_packet),
		.pop_words   (pop_words),
		.rd_data     (rd_data)
	);

	// One length per kept frame
	cdc_len_fifo u_len_fifo (
		.wr_clk   (rx_clk),
		.wr_reset (wr_reset),
		.wr_en    (len_wr_en),
		.wr_data  (len_wr_data),
		.rd_clk   (clk_mem),
		.rd_reset (rd_reset),
		.rd_en    (len_rd_en),
		.wr_full  (len_full),
		.rd_data  (len_rd_data),
		.rd_empty (len_empty)
	);

	mem_frame_reader u_reader (
		.clk_mem           (clk_mem),
		.rd_reset          (rd_reset),
		.len_empty         (len_empty),
		.len_rd_data       (len_rd_data),
		.mem_frame_start   (mem_frame_start),
		.rd_data           (rd_data),
		.len_rd_en         (len_rd_en),
		.rd_en             (rd_en),
		.rd_offset         (rd_offset),
		.pop_packet        (pop_packet),
		.pop_words         (pop_words),
		.mem_frame_ready   (mem_frame_ready),
		.mem_frame_bytelen (mem_frame_bytelen),
		.mem_valid         (mem_valid),
		.mem_data          (mem_data),
		.mem_frame_done    (mem_frame_done)
	);

endmodule

// ==== design/eth_ingress_config.svh ====
`ifndef ETH_INGRESS_CONFIG_SVH
`define ETH_INGRESS_CONFIG_SVH

// Datapath widths
`define LANE_BITS 32
`define MEM_WORD_BITS 128
`define LEN_BITS 11

// Largest frame kept, in bytes
`define MAX_FRAME_BYTES 1522

// Packet data FIFO, in 128-bit words
`define DATA_FIFO_DEPTH 512
`define DATA_PTR_BITS 9

// Frame length FIFO, in entries
`define LEN_FIFO_DEPTH 64
`define LEN_PTR_BITS 6

`endif

// ==== design/eth_ingress_pkg.sv ====
`include "eth_ingress_config.svh"

package eth_ingress_pkg;

	// One memory word
	// Flat on the memory side, four MAC lanes on the rx side
	// Lane 3 sits at the top and is filled first
	typedef union packed {
		logic [`MEM_WORD_BITS-1:0]        flat;
		logic [3:0][`LANE_BITS-1:0]       lanes;
	} mem_word_u;

	// Frame length in bytes
	// Upper bits count whole 16-byte words, low nibble is the tail
	typedef union packed {
		logic [`LEN_BITS-1:0] bytes;
		struct packed {
			logic [`LEN_BITS-5:0] words;
			logic [3:0]           tail;
		} split;
	} frame_len_u;

endpackage

// ==== design/ingress_link_reset.sv ====
`timescale 1ns/1ps

module ingress_link_reset (
	input  logic rx_clk,
	input  logic clk_mem,
	input  logic rst,
	input  logic link_up,
	output logic wr_reset,
	output logic rd_reset
);

	logic       rst_meta;
	logic       rst_sync;
	logic       link_q;
	logic       link_edge;
	logic [1:0] link_hold;
	logic       rd_meta;
	logic       rd_sync;

	// Any change of link state flushes the buffers
	assign link_edge = link_up ^ link_q;

	always_ff @(posedge rx_clk) begin
		// rst into rx_clk through two flops
		rst_meta <= rst;
		rst_sync <= rst_meta;
		link_q   <= link_up;
		// Stretch the link pulse so the slower clk_mem sees it
		if (rst_sync)
			link_hold <= 2'd0;
		else if (link_edge)
			link_hold <= 2'd2;
		else if (link_hold != 2'd0)
			link_hold <= link_hold - 2'd1;
		wr_reset <= link_edge || (link_hold != 2'd0) || rst_sync;
	end

	// Write side reset back into clk_mem
	always_ff @(posedge clk_mem) begin
		rd_meta <= wr_reset;
		rd_sync <= rd_meta;
	end

	assign rd_reset = rd_sync || rst;

endmodule

// ==== design/mem_frame_reader.sv ====
`timescale 1ns/1ps
`include "eth_ingress_config.svh"

module mem_frame_reader
	import eth_ingress_pkg::*;
(
	input  logic                       clk_mem,
	input  logic                       rd_reset,
	input  logic                       len_empty,
	input  frame_len_u                 len_rd_data,
	input  logic                       mem_frame_start,
	input  mem_word_u                  rd_data,
	output logic                       len_rd_en,
	output logic                       rd_en,
	output logic [`DATA_PTR_BITS-1:0]  rd_offset,
	output logic                       pop_packet,
	output logic [`DATA_PTR_BITS:0]    pop_words,
	output logic                       mem_frame_ready,
	output logic [`LEN_BITS-1:0]       mem_frame_bytelen,
	output logic                       mem_valid,
	output logic [`MEM_WORD_BITS-1:0]  mem_data,
	output logic                       mem_frame_done
);

	localparam int WC_BITS = `DATA_PTR_BITS + 1;

	logic                       busy;
	logic                       len_rd_q;
	logic                       sending;
	logic                       rd_valid;
	logic                       last_word;
	logic [`DATA_PTR_BITS-1:0]  offset_q;
	logic [WC_BITS-1:0]         word_count;

	always_comb begin
		// Fetch the next length only when idle
		len_rd_en = !busy && !len_empty;
		rd_en     = 1'b0;
		rd_offset = offset_q;
		last_word = 1'b0;
		// Word 0 is already waiting when the host starts
		mem_valid = ((mem_frame_start && mem_frame_ready) || sending) && rd_valid;
		// Prefetch word 0 together with the length
		if (len_rd_en) begin
			rd_en     = 1'b1;
			rd_offset = '0;
		end
		if (mem_valid) begin
			rd_offset = offset_q + 1'b1;
			if ({1'b0, rd_offset} >= word_count)
				last_word = 1'b1;
			else
				rd_en = 1'b1;
		end
	end

	// Pop in the last cycle so the next prefetch sees the new pointer
	assign pop_packet     = last_word;
	assign pop_words      = word_count;
	assign mem_frame_done = last_word;
	assign mem_data       = rd_data.flat;

	always_ff @(posedge clk_mem) begin
		if (rd_reset) begin
			busy            <= 1'b0;
			len_rd_q        <= 1'b0;
			sending         <= 1'b0;
			rd_valid        <= 1'b0;
			offset_q        <= '0;
			mem_frame_ready <= 1'b0;
		end else begin
			len_rd_q <= len_rd_en;
			offset_q <= rd_offset;
			// Read data is consumed, then refilled
			if (mem_valid)
				rd_valid <= 1'b0;
			if (rd_en)
				rd_valid <= 1'b1;
			if (len_rd_en)
				busy <= 1'b1;
			// Length arrived, announce the frame
			if (len_rd_q)
				mem_frame_ready <= 1'b1;
			if (mem_frame_start && mem_frame_ready) begin
				sending         <= 1'b1;
				mem_frame_ready <= 1'b0;
			end
			if (last_word) begin
				sending <= 1'b0;
				busy    <= 1'b0;
			end
		end
	end

	// Length and word count from the registered length word
	always_ff @(posedge clk_mem) begin
		if (len_rd_q) begin
			mem_frame_bytelen <= len_rd_data.bytes;
			word_count        <= WC_BITS'(len_rd_data.split.words) +
				WC_BITS'(len_rd_data.split.tail != 4'd0);
		end
	end

endmodule

// ==== design/rx_width_expander.sv ====
`timescale 1ns/1ps
`include "eth_ingress_config.svh"

module rx_width_expander
	import eth_ingress_pkg::*;
(
	input  logic                     rx_clk,
	input  logic                     wr_reset,
	input  logic                     rx_start,
	input  logic                     rx_data_valid,
	input  logic [`LANE_BITS-1:0]    rx_data,
	input  logic [2:0]               rx_bytes_valid,
	input  logic                     rx_commit,
	input  logic                     rx_drop,
	input  logic [`DATA_PTR_BITS:0]  wr_free,
	input  logic                     len_full,
	output logic                     wr_en,
	output mem_word_u                wr_data,
	output logic                     wr_commit,
	output logic                     wr_rollback,
	output logic                     len_wr_en,
	output frame_len_u               len_wr_data
);

	logic [1:0]          phase;
	frame_len_u          byte_count;
	logic                dropping;
	logic                commit_next;
	logic [`LEN_BITS:0]  next_count;
	logic                word_drop;
	logic                active;
	logic                data_go;
	logic                commit_go;

	////////////////////////////////////////////////////////////
	// Drop decisions

	// One bit wider so an oversized frame cannot wrap
	assign next_count = {1'b0, byte_count.bytes} + {{(`LEN_BITS-2){1'b0}}, rx_bytes_valid};

	// Keep one spare word for the tail push at commit
	assign word_drop = (wr_free < 2) || (next_count > `MAX_FRAME_BYTES);

	// Start and drop take priority, dropped frames are ignored
	assign active    = !rx_start && !rx_drop && !dropping;
	assign data_go   = active && rx_data_valid && !word_drop;
	assign commit_go = active && !rx_data_valid && rx_commit;

	////////////////////////////////////////////////////////////
	// Control and strobes

	always_ff @(posedge rx_clk) begin
		// Single cycle strobes
		wr_en       <= 1'b0;
		wr_commit   <= 1'b0;
		wr_rollback <= 1'b0;
		commit_next <= 1'b0;
		len_wr_en   <= 1'b0;
		if (wr_reset) begin
			phase      <= 2'd0;
			byte_count <= '0;
			dropping   <= 1'b0;
		end else begin
			// Commit waits one cycle behind the tail word
			if (commit_next)
				wr_commit <= 1'b1;

			if (rx_start) begin
				phase            <= 2'd0;
				byte_count.bytes <= '0;
				// No room to record the length
				dropping         <= len_full;
			end else if (rx_drop) begin
				// MAC abort, discard what was pushed
				wr_rollback <= 1'b1;
				dropping    <= 1'b1;
			end else if (!dropping && rx_data_valid) begin
				if (word_drop) begin
					dropping    <= 1'b1;
					wr_rollback <= 1'b1;
				end else begin
					phase            <= phase + 2'd1;
					byte_count.bytes <= next_count[`LEN_BITS-1:0];
					// Last lane of the group
					if (phase == 2'd3)
						wr_en <= 1'b1;
				end
			end else if (commit_go) begin
				len_wr_en <= 1'b1;
				if (phase == 2'd0) begin
					wr_commit <= 1'b1;
				end else begin
					// Partial group still to push
					wr_en       <= 1'b1;
					commit_next <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Payload

	always_ff @(posedge rx_clk) begin
		if (data_go)
			wr_data.lanes[2'd3 - phase] <= rx_data;
		if (commit_go) begin
			len_wr_data <= byte_count;
			// Clear lanes past the end of the frame
			for (int i = 0; i < 4; i++) begin
				if (i + int'(phase) < 4)
					wr_data.lanes[i] <= '0;
			end
		end
	end

endmodule

// ==== flist.f ====
+incdir+design
design/eth_ingress_pkg.sv
design/rx_width_expander.sv
design/ingress_link_reset.sv
design/cdc_packet_fifo.sv
design/cdc_len_fifo.sv
design/mem_frame_reader.sv
design/eth_ingress_cdc.sv
test/eth_ingress_chk.sv
test/eth_ingress_monitor.sv
test/eth_ingress_tb.sv

// ==== test/eth_ingress_chk.sv ====
`timescale 1ns/1ps

module eth_ingress_chk (
	input logic clk_mem,
	input logic rst,
	input logic mem_frame_start,
	input logic mem_frame_ready,
	input logic mem_valid,
	input logic mem_frame_done
);

	int fail_count = 0;

	// Data only flows once the frame is taken
	a_valid_ready: assert property (@(posedge clk_mem) disable iff (rst)
		(mem_valid && mem_frame_ready) |-> mem_frame_start)
		else begin
			$error("mem_valid high while the frame is still only announced");
			fail_count++;
		end

	a_done_valid: assert property (@(posedge clk_mem) disable iff (rst)
		mem_frame_done |-> mem_valid)
		else begin
			$error("mem_frame_done without mem_valid");
			fail_count++;
		end

	a_ready_falls: assert property (@(posedge clk_mem) disable iff (rst)
		(mem_frame_start && mem_frame_ready) |=> !mem_frame_ready)
		else begin
			$error("mem_frame_ready still high after the start");
			fail_count++;
		end

	a_reset_low: assert property (@(posedge clk_mem)
		rst |=> (!mem_frame_ready && !mem_valid && !mem_frame_done))
		else begin
			$error("memory side outputs not low after rst");
			fail_count++;
		end

endmodule

bind eth_ingress_cdc eth_ingress_chk u_chk (
	.clk_mem         (clk_mem),
	.rst             (rst),
	.mem_frame_start (mem_frame_start),
	.mem_frame_ready (mem_frame_ready),
	.mem_valid       (mem_valid),
	.mem_frame_done  (mem_frame_done)
);

// ==== test/eth_ingress_monitor.sv ====
`timescale 1ns/1ps
`include "eth_ingress_config.svh"

module eth_ingress_monitor (
	input logic                       clk_mem,
	input logic                       rst,
	input logic [`LEN_BITS-1:0]       mem_frame_bytelen,
	input logic                       mem_valid,
	input logic [`MEM_WORD_BITS-1:0]  mem_data,
	input logic                       mem_frame_done
);

	// Filled by the testbench, one entry per kept frame
	int                         exp_len[$];
	logic [7:0]                 exp_bytes[$];
	int                         errors = 0;
	int                         frames_seen = 0;

	int                         word_idx = 0;
	int                         cur_len;
	int                         cur_words;
	logic [`MEM_WORD_BITS-1:0]  exp_word;
	int                         idx;

	always @(posedge clk_mem) begin
		if (!rst && mem_valid) begin
			if (word_idx == 0 && exp_len.size() == 0) begin
				$display("error at %0t: a frame came out that was never kept", $time);
				errors++;
			end else begin
				if (word_idx == 0) begin
					cur_len   = exp_len[0];
					cur_words = (cur_len + 15) / 16;
					if (int'(mem_frame_bytelen) != cur_len) begin
						$display("error at %0t: mem_frame_bytelen got %0d expected %0d",
							$time, mem_frame_bytelen, cur_len);
						errors++;
					end
				end
				// Byte 0 of the word at the top, zero past the frame end
				for (int b = 0; b < 16; b++) begin
					idx = word_idx * 16 + b;
					exp_word[127 - 8 * b -: 8] = (idx < cur_len) ? exp_bytes[idx] : 8'h00;
				end
				if (mem_data !== exp_word) begin
					$display("error at %0t: mem_data got %h expected %h",
						$time, mem_data, exp_word);
					errors++;
				end
				if (mem_frame_done !== (word_idx == cur_words - 1)) begin
					$display("error at %0t: mem_frame_done got %b expected %b",
						$time, mem_frame_done, word_idx == cur_words - 1);
					errors++;
				end
				word_idx++;
				// Frame finished, retire it
				if (word_idx == cur_words) begin
					void'(exp_len.pop_front());
					for (int i = 0; i < cur_len; i++)
						void'(exp_bytes.pop_front());
					word_idx = 0;
					frames_seen++;
				end
			end
		end else if (!rst && word_idx != 0) begin
			$display("error at %0t: mem_valid went low inside a frame at word %0d",
				$time, word_idx);
			errors++;
		end
	end

endmodule

// ==== test/eth_ingress_tb.sv ====
`timescale 1ns/1ps
`include "eth_ingress_config.svh"

module eth_ingress_tb;

	// MAC side
	logic                       rx_clk;
	logic                       link_up;
	logic                       rx_start;
	logic                       rx_data_valid;
	logic [`LANE_BITS-1:0]      rx_data;
	logic [2:0]                 rx_bytes_valid;
	logic                       rx_commit;
	logic                       rx_drop;
	// Memory side
	logic                       clk_mem;
	logic                       rst;
	logic                       mem_frame_start;
	logic                       mem_frame_ready;
	logic [`LEN_BITS-1:0]       mem_frame_bytelen;
	logic                       mem_valid;
	logic [`MEM_WORD_BITS-1:0]  mem_data;
	logic                       mem_frame_done;

	// Trace rows
	int          tr_op[$];
	int          tr_len[$];
	int          tr_kept[$];
	int          tr_delay[$];
	bit          trace_ok;
	bit          trace_loaded;
	longint      limit_ns;
	int          tb_errors;
	integer      seed;
	logic [7:0]  payload[$];
	// Host hold per kept frame, in frame order
	int          host_delays[$];
	// Host leaves an announced frame alone while set
	bit          host_block;

	eth_ingress_cdc u_dut (.*);

	eth_ingress_monitor u_mon (
		.clk_mem           (clk_mem),
		.rst               (rst),
		.mem_frame_bytelen (mem_frame_bytelen),
		.mem_valid         (mem_valid),
		.mem_data          (mem_data),
		.mem_frame_done    (mem_frame_done)
	);

	////////////////////////////////////////////////////////////
	// Clocks

	initial begin
		clk_mem = 1'b0;
		forever #20 clk_mem = ~clk_mem;
	end

	initial begin
		rx_clk = 1'b0;
		forever #16 rx_clk = ~rx_clk;
	end

	////////////////////////////////////////////////////////////
	// Trace file

	// Columns are op, byte length, kept flag and host delay
	task automatic load_trace();
		int    fd;
		int    r;
		int    op;
		int    len;
		int    kept;
		int    dly;
		string line;
		fd = $fopen("test/eth_ingress_trace.txt", "r");
		trace_ok = (fd != 0);
		if (fd != 0) begin
			while (!$feof(fd)) begin
				r = $fgets(line, fd);
				// Skip comment lines
				if (r > 0 && line.len() > 0 && line[0] != "#") begin
					if ($sscanf(line, "%d %d %d %d", op, len, kept, dly) == 4) begin
						tr_op.push_back(op);
						tr_len.push_back(len);
						tr_kept.push_back(kept);
						tr_delay.push_back(dly);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	////////////////////////////////////////////////////////////
	// MAC stimulus

	// First byte of each lane sits in the top bits
	task automatic send_frame(input int len, input bit abort);
		int                    nlanes;
		int                    nb;
		logic [`LANE_BITS-1:0] w;
		nlanes = (len + 3) / 4;
		@(posedge rx_clk);
		#2;
		rx_start = 1'b1;
		@(posedge rx_clk);
		#2;
		rx_start = 1'b0;
		for (int l = 0; l < nlanes; l++) begin
			w  = '0;
			nb = (len - 4 * l > 4) ? 4 : len - 4 * l;
			for (int b = 0; b < nb; b++)
				w[31 - 8 * b -: 8] = payload[4 * l + b];
			rx_data_valid  = 1'b1;
			rx_data        = w;
			rx_bytes_valid = 3'(nb);
			@(posedge rx_clk);
			#2;
		end
		rx_data_valid  = 1'b0;
		rx_data        = '0;
		rx_bytes_valid = 3'd0;
		if (abort)
			rx_drop = 1'b1;
		else
			rx_commit = 1'b1;
		@(posedge rx_clk);
		#2;
		rx_drop   = 1'b0;
		rx_commit = 1'b0;
		// Room for the delayed tail commit
		repeat (3) @(posedge rx_clk);
	endtask

	task automatic make_payload(input int len);
		int r;
		payload.delete();
		for (int i = 0; i < len; i++) begin
			r = $random(seed);
			payload.push_back(r[7:0]);
		end
	endtask

	// Park one announced frame in the FIFOs, then flush it with a link bounce
	// The parked frame is never expected, so it must not come out afterwards
	task automatic bounce_link();
		while (u_mon.exp_len.size() != 0)
			@(posedge clk_mem);
		host_block = 1'b1;
		make_payload(64);
		send_frame(64, 1'b0);
		// Committed and announced, held back from the host
		while (mem_frame_ready !== 1'b1)
			@(posedge clk_mem);
		@(posedge rx_clk);
		#2;
		link_up = 1'b0;
		repeat (12) @(posedge rx_clk);
		#2;
		link_up = 1'b1;
		repeat (12) @(posedge rx_clk);
		host_block = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Host side start pulses

	initial begin : host
		int d;
		wait (rst === 1'b0);
		forever begin
			@(posedge clk_mem);
			if (mem_frame_ready && !host_block) begin
				d = (host_delays.size() != 0) ? host_delays.pop_front() : 0;
				// Frame must wait untouched while the host holds off
				for (int k = 0; k < d; k++) begin
					@(posedge clk_mem);
					if (mem_frame_ready !== 1'b1) begin
						$display("error at %0t: mem_frame_ready got %b expected 1",
							$time, mem_frame_ready);
						tb_errors++;
					end
					if (mem_valid !== 1'b0) begin
						$display("error at %0t: mem_valid got %b expected 0",
							$time, mem_valid);
						tb_errors++;
					end
				end
				#2;
				mem_frame_start = 1'b1;
				@(posedge clk_mem);
				#2;
				mem_frame_start = 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Watchdog

	initial begin : watchdog
		wait (trace_loaded);
		#(limit_ns);
		$display("timeout: frames still expected after %0d ns", limit_ns);
		$display("STATUS: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin : main
		int total;
		rst             = 1'b1;
		link_up         = 1'b1;
		rx_start        = 1'b0;
		rx_data_valid   = 1'b0;
		rx_data         = '0;
		rx_bytes_valid  = 3'd0;
		rx_commit       = 1'b0;
		rx_drop         = 1'b0;
		mem_frame_start = 1'b0;
		host_block      = 1'b0;
		tb_errors       = 0;
		seed            = 32'h4d5e659b;
		trace_loaded    = 1'b0;
		load_trace();
		if (!trace_ok) begin
			$display("could not open the trace file test/eth_ingress_trace.txt");
			$display("STATUS: FAIL");
			$finish;
		end else begin
			// Time budget from the trace contents
			limit_ns = 2000;
			foreach (tr_len[i])
				limit_ns += longint'(tr_len[i]) * 4 * 32 + longint'(tr_delay[i]) * 40;
			trace_loaded = 1'b1;
			repeat (3) @(posedge clk_mem);
			#2;
			rst = 1'b0;
			repeat (10) @(posedge rx_clk);
			foreach (tr_op[i]) begin
				if (tr_op[i] == 2) begin
					bounce_link();
				end else begin
					make_payload(tr_len[i]);
					// Expected frame goes in before the MAC sends it
					if (tr_kept[i] != 0) begin
						u_mon.exp_len.push_back(tr_len[i]);
						foreach (payload[j])
							u_mon.exp_bytes.push_back(payload[j]);
						host_delays.push_back(tr_delay[i]);
					end
					send_frame(tr_len[i], tr_op[i] == 1);
				end
			end
			while (u_mon.exp_len.size() != 0)
				@(posedge clk_mem);
			// Catch any stray frame after the last one
			repeat (50) @(posedge clk_mem);
			total = tb_errors + u_mon.errors + u_dut.u_chk.fail_count;
			$display("errors: monitor %0d, testbench %0d, assertions %0d, frames %0d",
				u_mon.errors, tb_errors, u_dut.u_chk.fail_count, u_mon.frames_seen);
			if (total == 0)
				$display("STATUS: PASS");
			else
				$display("STATUS: FAIL");
			$finish;
		end
	end

endmodule

// ==== test/eth_ingress_trace.txt ====
# op: 0 frame, 1 MAC drop, 2 link bounce, 3 host hold
# columns: op bytelen kept host_delay
0 64 1 0
0 65 1 3
0 100 1 0
0 1500 1 5
0 1522 1 0
0 77 1 2
1 200 0 0
0 128 1 0
0 1600 0 0
0 90 1 1
0 1523 0 0
0 60 1 0
2 0 0 0
0 64 1 0
0 333 1 4
3 256 1 300
0 64 1 0
0 150 1 0
0 47 1 2
0 16 1 0
